/* include/ft_consts.svh */
`ifndef FT_CONSTS_SVH
`define FT_CONSTS_SVH

// control, spectrum and debug words
`define FT_WORD_W        32

// one ADC sample
`define FT_SAMPLE_W      16

// FFT core configuration channel
`define FT_CFG_W         24

// spectrum capture memory
`define FT_CAPTURE_DEPTH 4096
`define FT_CAPTURE_AW    12

// accepted samples before a transform may start
`define FT_RECORD_MIN    1024

// debug counters
`define FT_EVT_CNT_W     3

// window select field of the control word
`define FT_WIN_SEL_W     3

`endif

/* source/ft_ctrl_pkg.sv */
`default_nettype none

`include "ft_consts.svh"

package ft_ctrl_pkg;

    // run state, also reported in the debug word
    typedef enum logic [1:0] {
        ft_idle      = 2'd0,
        ft_record    = 2'd1,
        ft_transform = 2'd2,
        ft_done      = 2'd3
    } ft_state_t;

    ////////////////////////////////////////////////////
    // control word
    ////////////////////////////////////////////////////

    typedef struct packed {
        logic [7:0]               sample_rate;
        logic [`FT_WIN_SEL_W-1:0] window_sel;
        logic                     run;
        // upper bits double as the readback index
        logic [14:0]              fft_param;
        logic [4:0]               nfft;
    } ft_ctrl_word_t;

    // window geometry for one run
    typedef struct packed {
        logic [12:0] win_len;
        logic [7:0]  win_count;
    } ft_window_t;

endpackage

`default_nettype wire

/* source/ft_debug_pkg.sv */
`default_nettype none

`include "ft_consts.svh"

package ft_debug_pkg;

    // raw event inputs, frame_started in the top bit
    typedef struct packed {
        logic frame_started;
        logic tlast_unexpected;
        logic tlast_missing;
        logic fft_overflow;
        logic status_halt;
        logic data_in_halt;
        logic data_out_halt;
        logic fifo_empty;
        logic fifo_full;
    } ft_event_t;

    typedef logic [`FT_EVT_CNT_W-1:0] ft_evt_cnt_t;

    ////////////////////////////////////////////////////
    // debug status word
    ////////////////////////////////////////////////////

    typedef struct packed {
        logic [1:0]  zero;
        ft_evt_cnt_t fifo_empty_cnt;
        ft_evt_cnt_t fifo_full_cnt;
        ft_evt_cnt_t frame_started_cnt;
        ft_evt_cnt_t tlast_unexpected_cnt;
        ft_evt_cnt_t tlast_missing_cnt;
        ft_evt_cnt_t fft_overflow_cnt;
        ft_evt_cnt_t status_halt_cnt;
        ft_evt_cnt_t data_in_halt_cnt;
        ft_evt_cnt_t data_out_halt_cnt;
        logic [2:0]  state;
    } ft_debug_word_t;

endpackage

`default_nettype wire

/* source/ft_cfg_decode.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ft_consts.svh"

module ft_cfg_decode
    import ft_ctrl_pkg::*;
(
    input  wire                  aclk,
    input  wire                  reset_module,
    input  wire ft_ctrl_word_t   ctrl_word,
    input  wire ft_state_t       run_state,
    output logic [`FT_CFG_W-1:0] fft_cfg,
    output logic [7:0]           sample_frequency,
    output logic                 adc_or_dac,
    output logic [`FT_CFG_W-1:0] cfg_tdata,
    output logic                 cfg_tvalid,
    output ft_window_t           window,
    output logic                 run_req
);

    logic in_idle;

    assign in_idle = (run_state == ft_idle);

    // configuration only follows the control word between runs
    always_ff @(posedge aclk) begin
        if (in_idle) begin
            fft_cfg          <= {1'b0, ctrl_word.fft_param, 3'b000, ctrl_word.nfft};
            cfg_tdata        <= fft_cfg;
            sample_frequency <= ctrl_word.sample_rate;
            adc_or_dac       <= ctrl_word.fft_param[1];
            case (ctrl_word.window_sel)
                3'd0:    window <= '{win_len: 13'd4096, win_count: 8'd1};
                3'd1:    window <= '{win_len: 13'd2048, win_count: 8'd2};
                3'd2:    window <= '{win_len: 13'd1024, win_count: 8'd4};
                3'd3:    window <= '{win_len: 13'd512,  win_count: 8'd8};
                3'd4:    window <= '{win_len: 13'd256,  win_count: 8'd16};
                3'd5:    window <= '{win_len: 13'd128,  win_count: 8'd32};
                3'd6:    window <= '{win_len: 13'd64,   win_count: 8'd64};
                default: window <= '{win_len: 13'd32,   win_count: 8'd128};
            endcase
        end
    end

    // config channel is offered for the whole record phase
    always_ff @(posedge aclk) begin
        if (reset_module) begin
            cfg_tvalid <= 1'b0;
            run_req    <= 1'b0;
        end else begin
            cfg_tvalid <= (run_state == ft_record);
            run_req    <= ctrl_word.run;
        end
    end

endmodule

`default_nettype wire

/* source/ft_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ft_consts.svh"

module ft_sequencer
    import ft_ctrl_pkg::*;
(
    input  wire                     aclk,
    input  wire                     reset_module,
    input  wire                     run_req,
    input  wire ft_window_t         window,
    input  wire                     fifo_valid,
    input  wire                     fifo_ready,
    input  wire                     fifo_full,
    input  wire [`FT_SAMPLE_W-1:0]  sample_tdata,
    input  wire                     sample_tvalid,
    input  wire                     frame_tready,
    output logic                    sample_tready,
    output logic [`FT_SAMPLE_W-1:0] frame_tdata,
    output logic                    frame_tvalid,
    output logic                    frame_tlast,
    output logic                    ft_en,
    output ft_state_t               run_state
);

    localparam int CNT_W = 16;

    ft_state_t        state;
    logic [CNT_W-1:0] beat_cnt;
    logic [7:0]       win_cnt;
    logic             in_xform;
    logic             record_done;
    logic             frame_beat;
    logic             win_end;
    logic             last_win;

    ////////////////////////////////////////////////////
    // sample stream to the FFT
    ////////////////////////////////////////////////////

    assign in_xform      = (state == ft_transform);
    assign frame_tdata   = sample_tdata;
    assign frame_tvalid  = in_xform & sample_tvalid;
    // FIFO sees the FFT back-pressure in the same cycle
    assign sample_tready = in_xform & frame_tready;
    assign frame_beat    = frame_tvalid & frame_tready;

    assign win_end     = (beat_cnt == CNT_W'(window.win_len - 13'd1));
    assign last_win    = (win_cnt == window.win_count - 8'd1);
    assign frame_tlast = frame_tvalid & win_end;

    // FIFO full and drained into nothing, enough samples stored
    assign record_done = !fifo_ready && fifo_full && (beat_cnt >= CNT_W'(`FT_RECORD_MIN));

    ////////////////////////////////////////////////////
    // run FSM
    ////////////////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (reset_module) begin
            state    <= ft_idle;
            beat_cnt <= '0;
            win_cnt  <= '0;
            ft_en    <= 1'b0;
        end else begin
            ft_en <= (state == ft_record);
            case (state)
                ft_idle: begin
                    beat_cnt <= '0;
                    win_cnt  <= '0;
                    if (run_req) begin
                        state <= ft_record;
                    end
                end
                ft_record: begin
                    if (record_done) begin
                        state    <= ft_transform;
                        beat_cnt <= '0;
                    end else if (fifo_valid && fifo_ready && beat_cnt != '1) begin
                        beat_cnt <= beat_cnt + 1'b1;
                    end
                end
                ft_transform: begin
                    if (frame_beat && win_end) begin
                        beat_cnt <= '0;
                        if (last_win) begin
                            state <= ft_done;
                        end else begin
                            win_cnt <= win_cnt + 1'b1;
                        end
                    end else if (frame_beat) begin
                        beat_cnt <= beat_cnt + 1'b1;
                    end
                end
                ft_done: begin
                    if (!run_req) begin
                        state <= ft_idle;
                    end
                end
                default: state <= ft_idle;
            endcase
        end
    end

    assign run_state = state;

    // no stray beats reach the FFT after the last window
    a_frame_in_xform: assert property (@(posedge aclk) disable iff (reset_module)
        frame_beat && win_end && last_win |=> !frame_tvalid);

    // every window ends on a tlast beat
    a_tlast_in_window: assert property (@(posedge aclk) disable iff (reset_module)
        in_xform |-> beat_cnt < CNT_W'(window.win_len));

endmodule

`default_nettype wire

/* source/spectrum_capture.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ft_consts.svh"

module spectrum_capture
    import ft_ctrl_pkg::*;
(
    input  wire                   aclk,
    input  wire                   reset_module,
    input  wire ft_state_t        run_state,
    input  wire [`FT_WORD_W-1:0]  spectrum_tdata,
    input  wire                   spectrum_tvalid,
    input  wire ft_ctrl_word_t    ctrl_word,
    output logic                  spectrum_tready,
    output logic [`FT_WORD_W-1:0] readback_data
);

    logic [`FT_WORD_W-1:0]    mem [`FT_CAPTURE_DEPTH];
    logic [`FT_CAPTURE_AW-1:0] fill_cnt;
    logic [`FT_CAPTURE_AW-1:0] rd_addr;
    logic                      read_mode;
    logic                      wr_en;

    // readback index rides in the upper fft_param bits
    assign rd_addr = ctrl_word.fft_param[14:3];

    assign spectrum_tready = (run_state != ft_idle) && !read_mode;
    assign wr_en           = spectrum_tvalid && spectrum_tready;

    // fill pointer, read mode once the last word lands
    always_ff @(posedge aclk) begin
        if (reset_module || run_state == ft_idle) begin
            fill_cnt  <= '0;
            read_mode <= 1'b0;
        end else if (wr_en) begin
            fill_cnt <= fill_cnt + 1'b1;
            if (fill_cnt == `FT_CAPTURE_AW'(`FT_CAPTURE_DEPTH - 1)) begin
                read_mode <= 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (wr_en) begin
            mem[fill_cnt] <= spectrum_tdata;
        end
    end

    always_ff @(posedge aclk) begin
        if (read_mode) begin
            readback_data <= mem[rd_addr];
        end
    end

    // a full buffer stays closed until the run returns to idle
    a_no_write_full: assert property (@(posedge aclk) disable iff (reset_module)
        read_mode && run_state != ft_idle |=> !wr_en);

endmodule

`default_nettype wire

/* source/event_monitor.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ft_consts.svh"

module event_monitor
    import ft_ctrl_pkg::*;
    import ft_debug_pkg::*;
(
    input  wire                 aclk,
    input  wire                 reset_module,
    input  wire ft_state_t      run_state,
    input  wire ft_event_t      events,
    output ft_debug_word_t      debug_status
);

    localparam int N_EVT = $bits(ft_event_t);
    // level each event rests at between runs
    localparam ft_event_t EVT_IDLE = '{fifo_empty: 1'b1, default: 1'b0};

    logic [N_EVT-1:0] evt_prev;
    logic [N_EVT-1:0] evt_rise;
    logic             sampling;
    ft_evt_cnt_t      evt_cnt [N_EVT];

    assign sampling = (run_state == ft_record) || (run_state == ft_transform);
    assign evt_rise = {N_EVT{sampling}} & events & ~evt_prev;

    always_ff @(posedge aclk) begin
        if (reset_module || !sampling) begin
            evt_prev <= EVT_IDLE;
        end else begin
            evt_prev <= events;
        end
    end

    // saturating counters, cleared by reset only
    always_ff @(posedge aclk) begin
        for (int i = 0; i < N_EVT; i++) begin
            if (reset_module) begin
                evt_cnt[i] <= '0;
            end else if (evt_rise[i] && evt_cnt[i] != '1) begin
                evt_cnt[i] <= evt_cnt[i] + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////
    // status word, bit index follows ft_event_t
    ////////////////////////////////////////////////////

    always_comb begin
        debug_status.zero                 = 2'b00;
        debug_status.fifo_empty_cnt       = evt_cnt[1];
        debug_status.fifo_full_cnt        = evt_cnt[0];
        debug_status.frame_started_cnt    = evt_cnt[8];
        debug_status.tlast_unexpected_cnt = evt_cnt[7];
        debug_status.tlast_missing_cnt    = evt_cnt[6];
        debug_status.fft_overflow_cnt     = evt_cnt[5];
        debug_status.status_halt_cnt      = evt_cnt[4];
        debug_status.data_in_halt_cnt     = evt_cnt[3];
        debug_status.data_out_halt_cnt    = evt_cnt[2];
        debug_status.state                = {1'b0, run_state};
    end

    for (genvar i = 0; i < N_EVT; i++) begin : g_cnt_check
        a_cnt_monotonic: assert property (@(posedge aclk) disable iff (reset_module)
            !$past(reset_module) |-> evt_cnt[i] >= $past(evt_cnt[i]));
    end

endmodule

`default_nettype wire

/* source/ft_controller_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ft_consts.svh"

module ft_controller_top
    import ft_ctrl_pkg::*;
    import ft_debug_pkg::*;
(
    input  wire                     aclk,
    input  wire                     reset_module,
    input  wire ft_ctrl_word_t      ctrl_word,
    // sample FIFO side
    input  wire                     fifo_valid,
    input  wire                     fifo_ready,
    input  wire                     fifo_full,
    input  wire [`FT_SAMPLE_W-1:0]  sample_tdata,
    input  wire                     sample_tvalid,
    output wire                     sample_tready,
    // FFT core side
    output wire [`FT_SAMPLE_W-1:0]  frame_tdata,
    output wire                     frame_tvalid,
    output wire                     frame_tlast,
    input  wire                     frame_tready,
    output wire [`FT_CFG_W-1:0]     cfg_tdata,
    output wire                     cfg_tvalid,
    input  wire                     cfg_tready,
    output wire [`FT_CFG_W-1:0]     fft_cfg,
    output wire [7:0]               sample_frequency,
    output wire                     adc_or_dac,
    output wire                     ft_en,
    // spectrum capture
    input  wire [`FT_WORD_W-1:0]    spectrum_tdata,
    input  wire                     spectrum_tvalid,
    output wire                     spectrum_tready,
    output wire [`FT_WORD_W-1:0]    readback_data,
    // debug
    input  wire ft_event_t          events,
    output wire ft_debug_word_t     debug_status,
    output wire ft_state_t          run_state
);

    wire ft_window_t window;
    wire             run_req;

    ft_cfg_decode u_cfg_decode (
        .aclk             (aclk),
        .reset_module     (reset_module),
        .ctrl_word        (ctrl_word),
        .run_state        (run_state),
        .fft_cfg          (fft_cfg),
        .sample_frequency (sample_frequency),
        .adc_or_dac       (adc_or_dac),
        .cfg_tdata        (cfg_tdata),
        .cfg_tvalid       (cfg_tvalid),
        .window           (window),
        .run_req          (run_req)
    );

    ft_sequencer u_sequencer (
        .aclk          (aclk),
        .reset_module  (reset_module),
        .run_req       (run_req),
        .window        (window),
        .fifo_valid    (fifo_valid),
        .fifo_ready    (fifo_ready),
        .fifo_full     (fifo_full),
        .sample_tdata  (sample_tdata),
        .sample_tvalid (sample_tvalid),
        .frame_tready  (frame_tready),
        .sample_tready (sample_tready),
        .frame_tdata   (frame_tdata),
        .frame_tvalid  (frame_tvalid),
        .frame_tlast   (frame_tlast),
        .ft_en         (ft_en),
        .run_state     (run_state)
    );

    spectrum_capture u_capture (
        .aclk            (aclk),
        .reset_module    (reset_module),
        .run_state       (run_state),
        .spectrum_tdata  (spectrum_tdata),
        .spectrum_tvalid (spectrum_tvalid),
        .ctrl_word       (ctrl_word),
        .spectrum_tready (spectrum_tready),
        .readback_data   (readback_data)
    );

    event_monitor u_event_monitor (
        .aclk         (aclk),
        .reset_module (reset_module),
        .run_state    (run_state),
        .events       (events),
        .debug_status (debug_status)
    );

endmodule

`default_nettype wire

/* dv/ft_controller_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ft_consts.svh"

module ft_controller_tb
    import ft_ctrl_pkg::*;
    import ft_debug_pkg::*;
();

    localparam int CLK_PERIOD   = 20;
    localparam int DRIVE_DELAY  = 2;
    localparam int RESET_CYCLES = 4;
    localparam int MAX_TESTS    = 32;
    localparam int MAX_PULSES   = 16;
    localparam int WAIT_LIMIT   = 64;
    localparam int RUN_BIT      = 20;
    localparam int READBACKS    = 16;
    // fifo_empty rests high, every other event low
    localparam logic [8:0] EVT_REST = 9'b0_0000_0010;

    logic                      aclk;
    logic                      reset_module;
    ft_ctrl_word_t             ctrl_word;
    logic                      fifo_valid;
    logic                      fifo_ready;
    logic                      fifo_full;
    logic [`FT_SAMPLE_W-1:0]   sample_tdata;
    logic                      sample_tvalid;
    logic                      sample_tready;
    logic [`FT_SAMPLE_W-1:0]   frame_tdata;
    logic                      frame_tvalid;
    logic                      frame_tlast;
    logic                      frame_tready;
    logic [`FT_CFG_W-1:0]      cfg_tdata;
    logic                      cfg_tvalid;
    logic                      cfg_tready;
    logic [`FT_CFG_W-1:0]      fft_cfg;
    logic [7:0]                sample_frequency;
    logic                      adc_or_dac;
    logic                      ft_en;
    logic [`FT_WORD_W-1:0]     spectrum_tdata;
    logic                      spectrum_tvalid;
    logic                      spectrum_tready;
    logic [`FT_WORD_W-1:0]     readback_data;
    ft_event_t                 events;
    ft_debug_word_t            debug_status;
    ft_state_t                 run_state;

    int          test_id     [MAX_TESTS];
    logic [31:0] test_word   [MAX_TESTS];
    int          test_bp     [MAX_TESTS];
    int          test_pulses [MAX_TESTS];
    int          n_tests;
    int          errors;
    int          checks;
    int          evt_ref     [9];
    logic [8:0]  pulse_mask  [MAX_PULSES];
    logic [31:0] cap_ref     [`FT_CAPTURE_DEPTH];
    logic [31:0] lfsr_state;
    longint      wd_cycles;
    logic        wd_armed = 1'b0;

    ft_controller_top uut (
        .aclk             (aclk),
        .reset_module     (reset_module),
        .ctrl_word        (ctrl_word),
        .fifo_valid       (fifo_valid),
        .fifo_ready       (fifo_ready),
        .fifo_full        (fifo_full),
        .sample_tdata     (sample_tdata),
        .sample_tvalid    (sample_tvalid),
        .sample_tready    (sample_tready),
        .frame_tdata      (frame_tdata),
        .frame_tvalid     (frame_tvalid),
        .frame_tlast      (frame_tlast),
        .frame_tready     (frame_tready),
        .cfg_tdata        (cfg_tdata),
        .cfg_tvalid       (cfg_tvalid),
        .cfg_tready       (cfg_tready),
        .fft_cfg          (fft_cfg),
        .sample_frequency (sample_frequency),
        .adc_or_dac       (adc_or_dac),
        .ft_en            (ft_en),
        .spectrum_tdata   (spectrum_tdata),
        .spectrum_tvalid  (spectrum_tvalid),
        .spectrum_tready  (spectrum_tready),
        .readback_data    (readback_data),
        .events           (events),
        .debug_status     (debug_status),
        .run_state        (run_state)
    );

    initial aclk = 1'b0;
    always #(CLK_PERIOD / 2) aclk = ~aclk;

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    // galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return out;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_bit()};
        end
        return r;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[ERROR] %0t ns %s got 0x%0h expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic next_drive_slot();
        @(posedge aclk);
        #DRIVE_DELAY;
    endtask

    task automatic wait_for_state(input logic [1:0] want, input string name);
        int n;
        n = 0;
        @(negedge aclk);
        while (run_state != want && n < WAIT_LIMIT) begin
            @(negedge aclk);
            n++;
        end
        if (run_state != want) begin
            errors++;
            $display("%0t ns: the run never reached the %s state", $time, name);
        end
    endtask

    task automatic check_debug(input logic [1:0] exp_state);
        logic [31:0] exp;
        exp = {2'b00, 3'(evt_ref[1]), 3'(evt_ref[0]), 3'(evt_ref[8]), 3'(evt_ref[7]),
               3'(evt_ref[6]), 3'(evt_ref[5]), 3'(evt_ref[4]), 3'(evt_ref[3]),
               3'(evt_ref[2]), 1'b0, exp_state};
        compare_value("debug_status.state", debug_status.state, {1'b0, exp_state});
        compare_value("debug_status", debug_status, exp);
    endtask

    task automatic fill_masks(input int n);
        for (int p = 0; p < n; p++) begin
            pulse_mask[p] = rand_bits(9);
        end
    endtask

    // one pulse per masked event, fifo_empty pulses low then back high
    task automatic pulse_events(input int n, input bit counted);
        logic [8:0] mask;
        for (int p = 0; p < n; p++) begin
            mask = pulse_mask[p];
            next_drive_slot();
            events = EVT_REST ^ mask;
            for (int b = 0; b < 9; b++) begin
                if (counted && mask[b] && evt_ref[b] < 7) begin
                    evt_ref[b]++;
                end
            end
            next_drive_slot();
            events = EVT_REST;
        end
        next_drive_slot();
    endtask

    task automatic feed_record(input logic [`FT_CFG_W-1:0] exp_cfg);
        for (int n = 0; n < `FT_RECORD_MIN + 8; n++) begin
            next_drive_slot();
            fifo_valid = 1'b1;
            fifo_ready = 1'b1;
            @(negedge aclk);
            compare_value("run_state", run_state, ft_record);
            compare_value("cfg_tvalid", cfg_tvalid, 1'b1);
            compare_value("cfg_tdata", cfg_tdata, exp_cfg);
            compare_value("ft_en", ft_en, 1'b1);
            compare_value("sample_tready", sample_tready, 1'b0);
        end
    endtask

    task automatic stream_frames(input int win_len, input int total, input int bp);
        int         beat;
        bit         accepted;
        logic [15:0] data;
        beat = 0;
        accepted = 1'b1;
        data = '0;
        while (beat < total) begin
            next_drive_slot();
            if (accepted) begin
                data = rand_bits(16);
            end
            sample_tdata  = data;
            sample_tvalid = 1'b1;
            fifo_full     = 1'b0;
            frame_tready  = (bp != 0) ? (rand_bits(1) != 32'd0) : 1'b1;
            @(negedge aclk);
            compare_value("sample_tready", sample_tready, frame_tready);
            compare_value("frame_tvalid", frame_tvalid, 1'b1);
            compare_value("frame_tdata", frame_tdata, data);
            compare_value("frame_tlast", frame_tlast, (beat % win_len) == win_len - 1);
            accepted = frame_tready;
            if (accepted) begin
                beat++;
            end
        end
    endtask

    task automatic capture_spectrum(input int bp);
        int wr;
        wr = 0;
        while (wr < `FT_CAPTURE_DEPTH) begin
            next_drive_slot();
            spectrum_tdata  = rand_bits(32);
            spectrum_tvalid = (bp != 0) ? (rand_bits(1) != 32'd0) : 1'b1;
            @(negedge aclk);
            compare_value("spectrum_tready", spectrum_tready, 1'b1);
            if (spectrum_tvalid) begin
                cap_ref[wr] = spectrum_tdata;
                wr++;
            end
        end
        next_drive_slot();
        spectrum_tvalid = 1'b1;
        @(negedge aclk);
        compare_value("spectrum_tready", spectrum_tready, 1'b0);
    endtask

    //////////////////////////////////////////////////
    // one run per stimulus line
    //////////////////////////////////////////////////

    task automatic run_test(input int t);
        logic [31:0]          word;
        logic [31:0]          rb_word;
        logic [11:0]          idx;
        logic [`FT_CFG_W-1:0] exp_cfg;
        int                   sel;
        int                   win_len;
        int                   total;
        int                   pulses;
        word    = test_word[t] & ~(32'd1 << RUN_BIT);
        exp_cfg = {1'b0, word[19:5], 3'b000, word[4:0]};
        sel     = word[23:21];
        win_len = 4096 >> sel;
        total   = win_len * (1 << sel);
        pulses  = (test_pulses[t] > MAX_PULSES) ? MAX_PULSES : test_pulses[t];
        $display("test %0d: %0d x %0d samples, back-pressure %0d, %0d pulses",
                 test_id[t], win_len, 1 << sel, test_bp[t], pulses);

        next_drive_slot();
        ctrl_word = word;
        @(posedge aclk);
        @(negedge aclk);
        compare_value("fft_cfg", fft_cfg, exp_cfg);
        compare_value("sample_frequency", sample_frequency, word[31:24]);
        compare_value("adc_or_dac", adc_or_dac, word[6]);
        compare_value("cfg_tvalid", cfg_tvalid, 1'b0);
        compare_value("ft_en", ft_en, 1'b0);

        // idle pulses leave the counters alone
        fill_masks(pulses);
        pulse_events(pulses, 1'b0);
        @(negedge aclk);
        check_debug(ft_idle);

        next_drive_slot();
        ctrl_word = word | (32'd1 << RUN_BIT);
        wait_for_state(ft_record, "record");
        fill_masks(pulses);
        fork
            pulse_events(pulses, 1'b1);
            feed_record(exp_cfg);
        join

        // ready low alone must not start the transform
        next_drive_slot();
        fifo_valid = 1'b0;
        fifo_ready = 1'b0;
        @(negedge aclk);
        compare_value("run_state", run_state, ft_record);
        check_debug(ft_record);
        next_drive_slot();
        fifo_full = 1'b1;
        wait_for_state(ft_transform, "transform");

        fill_masks(pulses);
        fork
            pulse_events(pulses, 1'b1);
            stream_frames(win_len, total, test_bp[t]);
        join
        next_drive_slot();
        @(negedge aclk);
        compare_value("frame_tvalid", frame_tvalid, 1'b0);
        compare_value("sample_tready", sample_tready, 1'b0);
        compare_value("run_state", run_state, ft_done);
        check_debug(ft_done);
        next_drive_slot();
        sample_tvalid = 1'b0;
        frame_tready  = 1'b1;

        capture_spectrum(test_bp[t]);
        for (int k = 0; k < READBACKS; k++) begin
            idx = (k == 0) ? 12'd0 : (k == 1) ? 12'hfff : rand_bits(12);
            rb_word = word | (32'd1 << RUN_BIT);
            rb_word[19:8] = idx;
            next_drive_slot();
            spectrum_tvalid = 1'b0;
            ctrl_word = rb_word;
            @(posedge aclk);
            @(negedge aclk);
            compare_value("readback_data", readback_data, cap_ref[idx]);
        end
        check_debug(ft_done);

        next_drive_slot();
        ctrl_word = word;
        wait_for_state(ft_idle, "idle");
        check_debug(ft_idle);
    endtask

    task automatic read_stimulus(output bit ok);
        int          fd;
        int          id;
        int          bp;
        int          pulses;
        logic [31:0] word;
        string       line;
        ok = 1'b0;
        n_tests = 0;
        fd = $fopen("dv/ft_stim.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd) && n_tests < MAX_TESTS) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line[0] != "#") begin
                    if ($sscanf(line, "%d %h %d %d", id, word, bp, pulses) == 4) begin
                        test_id[n_tests]     = id;
                        test_word[n_tests]   = word;
                        test_bp[n_tests]     = bp;
                        test_pulses[n_tests] = pulses;
                        n_tests++;
                    end
                end
            end
            $fclose(fd);
            ok = (n_tests > 0);
        end
    endtask

    //////////////////////////////////////////////////
    // main sequence and watchdog
    //////////////////////////////////////////////////

    initial begin
        bit ok;
        reset_module    = 1'b1;
        ctrl_word       = '0;
        fifo_valid      = 1'b0;
        fifo_ready      = 1'b0;
        fifo_full       = 1'b0;
        sample_tdata    = '0;
        sample_tvalid   = 1'b0;
        frame_tready    = 1'b1;
        cfg_tready      = 1'b1;
        spectrum_tdata  = '0;
        spectrum_tvalid = 1'b0;
        events          = EVT_REST;
        lfsr_state      = 32'd91914;
        errors          = 0;
        checks          = 0;
        for (int b = 0; b < 9; b++) begin
            evt_ref[b] = 0;
        end

        read_stimulus(ok);
        // window samples plus a full capture per test, four times over
        wd_cycles = 64;
        for (int t = 0; t < n_tests; t++) begin
            wd_cycles += (4096 >> test_word[t][23:21]) * (1 << test_word[t][23:21]);
            wd_cycles += `FT_CAPTURE_DEPTH;
        end
        wd_cycles = wd_cycles * 4;
        wd_armed  = 1'b1;

        repeat (RESET_CYCLES) @(posedge aclk);
        #DRIVE_DELAY;
        reset_module = 1'b0;

        if (!ok) begin
            $display("the stimulus file dv/ft_stim.txt could not be read");
            $display("errors: %0d, checks: %0d", errors, checks);
            $display("tests failed");
            $finish;
        end else begin
            for (int t = 0; t < n_tests; t++) begin
                run_test(t);
            end
            $display("errors: %0d, checks: %0d", errors, checks);
            if (errors == 0) begin
                $display("all tests passed");
            end else begin
                $display("tests failed");
            end
            $finish;
        end
    end

    initial begin
        wait (wd_armed);
        #(wd_cycles * CLK_PERIOD);
        $display("watchdog expired after %0d cycles before the tests finished", wd_cycles);
        $display("errors: %0d, checks: %0d", errors, checks);
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+include
source/ft_ctrl_pkg.sv
source/ft_debug_pkg.sv
source/ft_cfg_decode.sv
source/ft_sequencer.sv
source/spectrum_capture.sv
source/event_monitor.sv
source/ft_controller_top.sv
dv/ft_controller_tb.sv

/* dv/ft_stim.txt */
# columns: test id, control word in hex (run bit is set by the testbench),
# back-pressure flag, event pulses per phase
1 4002468C 0 1
2 8021578B 1 2
3 104FFFEA 0 0
4 FF600049 1 3
5 018AAAA8 1 1
6 7EA00007 0 2
7 33C54546 1 4
8 C4E20025 1 1
